//--- hw/ctrlPkg.sv
package ctrlPkg;

    // per-byte operation
    typedef enum logic {
        MODE_FWD = 1'b0,  // forward s-box
        MODE_INV = 1'b1   // inverse s-box
    } sboxMode_e;

    // register stages from inValid to outValid
    localparam int PIPE_DEPTH = 2;

endpackage

//--- hw/sboxPkg.sv
package sboxPkg;

    // GF(2^4) in polynomial basis, reduced by x^4 + x + 1
    localparam logic [4:0] GF16_POLY = 5'b10011;

    // GF(2^8) over GF(2^4) with y^2 + y + lambda, lambda = x^3 + x^2
    // trace of lambda is 1 so the quadratic has no root in GF(2^4)
    localparam logic [3:0] TOWER_LAMBDA = 4'hC;

    localparam int MAP_COUNT = 4;

    // matrix selects
    localparam int MAP_TO_TOWER = 0;
    localparam int MAP_FWD_OUT  = 1;
    localparam int MAP_INV_IN   = 2;
    localparam int MAP_TO_STD   = 3;

    // row r drives output bit r, bit i of the row picks input bit i
    // tower byte layout is {hi, lo} = hi * y + lo
    localparam logic [7:0] MAP_MATRIX [MAP_COUNT][8] = '{
        // std -> tower, column i is beta^i with beta = 0x21 in tower form
        '{8'h03, 8'hA8, 8'h5C, 8'h68, 8'h70, 8'hD2, 8'hAC, 8'hA0},
        // tower -> std merged with the forward affine matrix
        '{8'hF5, 8'hDF, 8'h49, 8'h95, 8'h5B, 8'h3E, 8'hD0, 8'hC6},
        // inverse affine matrix merged with std -> tower
        '{8'hED, 8'hE3, 8'hD4, 8'h98, 8'hF7, 8'h78, 8'h71, 8'hC6},
        // tower -> std, exact inverse of select 0
        '{8'hB1, 8'hB0, 8'h42, 8'h82, 8'h9A, 8'hD4, 8'h5E, 8'h54}
    };

    // additive constants per select
    // 0x45 is the inverse affine constant 0x05 carried into tower form
    localparam logic [7:0] MAP_CONST [MAP_COUNT] = '{
        8'h00,  // to tower
        8'h63,  // forward affine
        8'h45,  // inverse affine, tower form
        8'h00   // to std
    };

endpackage

//--- hw/sboxStageIf.sv
`timescale 1ns/1ps

interface sboxStageIf import ctrlPkg::*;;

    logic       valid;   // qualifies the rest in the same cycle
    sboxMode_e  mode;
    logic [3:0] dataHi;  // y coefficient
    logic [3:0] dataLo;  // constant term

    modport src (
        output valid,
        output mode,
        output dataHi,
        output dataLo
    );

    modport dst (
        input valid,
        input mode,
        input dataHi,
        input dataLo
    );

endinterface

//--- hw/linMap.sv
`timescale 1ns/1ps

// 8x8 matrix over GF(2) plus a constant, both taken from the package table
module linMap import sboxPkg::*; #(
    parameter int MatrixSel = MAP_TO_TOWER
) (
    input  logic [7:0] dataIn,
    output logic [7:0] dataOut
);

    logic [7:0] rowProd [8];  // input masked by each row

    for (genvar r = 0; r < 8; r++) begin : gRow
        assign rowProd[r] = dataIn & MAP_MATRIX[MatrixSel][r];

        // parity of the masked row, then flip by the constant bit
        assign dataOut[r] = (^rowProd[r]) ^ MAP_CONST[MatrixSel][r];
    end

endmodule

//--- hw/gfInverter.sv
`timescale 1ns/1ps

// multiplicative inverse in GF((2^4)^2), zero maps to zero
module gfInverter import sboxPkg::*; (
    input  logic [3:0] inHi,
    input  logic [3:0] inLo,
    output logic [3:0] outHi,
    output logic [3:0] outLo
);

    // GF(2^4) multiply, reduced by GF16_POLY
    function automatic logic [3:0] gfMul4(input logic [3:0] a, input logic [3:0] b);
        logic [6:0] prod;
        prod = '0;
        for (int i = 0; i < 4; i++) begin
            if (b[i]) begin
                prod ^= 7'(a) << i;
            end
        end
        // fold x^6..x^4 back down
        for (int k = 6; k >= 4; k--) begin
            if (prod[k]) begin
                prod ^= 7'(GF16_POLY) << (k - 4);
            end
        end
        return prod[3:0];
    endfunction

    // lambda * a^2
    function automatic logic [3:0] gfSqScale(input logic [3:0] a);
        logic [3:0] sq;
        sq = gfMul4(a, a);
        return gfMul4(sq, TOWER_LAMBDA);
    endfunction

    // table inverse, inv(w^k) = w^(15-k)
    function automatic logic [3:0] gfInv4(input logic [3:0] a);
        logic [3:0] res;
        case (a)
            4'h1:    res = 4'h1;
            4'h2:    res = 4'h9;
            4'h3:    res = 4'hE;
            4'h4:    res = 4'hD;
            4'h5:    res = 4'hB;
            4'h6:    res = 4'h7;
            4'h7:    res = 4'h6;
            4'h8:    res = 4'hF;
            4'h9:    res = 4'h2;
            4'hA:    res = 4'hC;
            4'hB:    res = 4'h5;
            4'hC:    res = 4'hA;
            4'hD:    res = 4'h4;
            4'hE:    res = 4'h3;
            4'hF:    res = 4'h8;
            default: res = 4'h0;  // zero has no inverse, pass it through
        endcase
        return res;
    endfunction

    logic [3:0] sumHl;
    logic [3:0] normVal;
    logic [3:0] normInv;

    assign sumHl = inHi ^ inLo;

    // norm = a * a^16 = lambda*hi^2 + lo*(hi + lo), lies in GF(2^4)
    assign normVal = gfSqScale(inHi) ^ gfMul4(sumHl, inLo);
    assign normInv = gfInv4(normVal);

    // a^-1 = (hi*y + (hi + lo)) / norm
    assign outHi = gfMul4(inHi, normInv);
    assign outLo = gfMul4(sumHl, normInv);

endmodule

//--- hw/sboxFront.sv
`timescale 1ns/1ps

module sboxFront import ctrlPkg::*, sboxPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       inValid,
    input  sboxMode_e  inMode,
    input  logic [7:0] inData,
    sboxStageIf.src    stage
);

    logic [7:0] fwdTower;    // plain basis change
    logic [7:0] invTower;    // inverse affine folded in
    logic [7:0] towerByte;

    linMap #(.MatrixSel(MAP_TO_TOWER)) uToTower (
        .dataIn  (inData),
        .dataOut (fwdTower)
    );

    linMap #(.MatrixSel(MAP_INV_IN)) uInvIn (
        .dataIn  (inData),
        .dataOut (invTower)
    );

    assign towerByte = (inMode == MODE_INV) ? invTower : fwdTower;

    // stage 1
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            stage.valid  <= 1'b0;
            stage.mode   <= MODE_FWD;
            stage.dataHi <= '0;
            stage.dataLo <= '0;
        end else begin
            stage.valid <= inValid;
            if (inValid) begin  // hold payload over idle cycles
                stage.mode   <= inMode;
                stage.dataHi <= towerByte[7:4];
                stage.dataLo <= towerByte[3:0];
            end
        end
    end

    // mode picks the matrix, so it must be known with every byte
    aModeKnown: assert property (
        @(posedge clk) disable iff (!rstN)
        inValid |-> !$isunknown(inMode)
    );

endmodule

//--- hw/sboxBack.sv
`timescale 1ns/1ps

module sboxBack import ctrlPkg::*, sboxPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    sboxStageIf.dst    stage,
    output logic       outValid,
    output logic [7:0] outData
);

    logic [3:0] invHi;
    logic [3:0] invLo;
    logic [7:0] invByte;   // inverse, still in tower form
    logic [7:0] fwdOut;    // forward s-box result
    logic [7:0] invOut;    // inverse s-box result
    logic [7:0] resByte;

    gfInverter uInv (
        .inHi  (stage.dataHi),
        .inLo  (stage.dataLo),
        .outHi (invHi),
        .outLo (invLo)
    );

    assign invByte = {invHi, invLo};

    linMap #(.MatrixSel(MAP_FWD_OUT)) uFwdOut (
        .dataIn  (invByte),
        .dataOut (fwdOut)
    );

    linMap #(.MatrixSel(MAP_TO_STD)) uToStd (
        .dataIn  (invByte),
        .dataOut (invOut)
    );

    assign resByte = (stage.mode == MODE_INV) ? invOut : fwdOut;

    // stage 2
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
            outData  <= '0;
        end else begin
            outValid <= stage.valid;
            if (stage.valid) begin
                outData <= resByte;
            end
        end
    end

    // inverse of a nonzero tower byte is never zero
    aInvNonZero: assert property (
        @(posedge clk) disable iff (!rstN)
        (stage.valid && ({stage.dataHi, stage.dataLo} != 8'h00)) |-> (invByte != 8'h00)
    );

    // one output per stage-1 byte, one cycle later, and none otherwise
    aValidFollows: assert property (
        @(posedge clk) disable iff (!rstN)
        stage.valid |=> outValid
    );

    aNoSpuriousValid: assert property (
        @(posedge clk) disable iff (!rstN)
        !stage.valid |=> !outValid
    );

endmodule

//--- hw/sboxUnit.sv
`timescale 1ns/1ps

// forward / inverse aes s-box, two stages, one byte per clock
module sboxUnit import ctrlPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       inValid,
    input  sboxMode_e  inMode,
    input  logic [7:0] inData,
    output logic       outValid,
    output logic [7:0] outData
);

    // tower byte between the stages
    sboxStageIf stageIf ();

    // basis change in
    sboxFront uFront (
        .clk     (clk),
        .rstN    (rstN),
        .inValid (inValid),
        .inMode  (inMode),
        .inData  (inData),
        .stage   (stageIf)
    );

    // inversion and basis change out
    sboxBack uBack (
        .clk      (clk),
        .rstN     (rstN),
        .stage    (stageIf),
        .outValid (outValid),
        .outData  (outData)
    );

endmodule

//--- sim/sboxChecker.sv
`timescale 1ns/1ps

// watches the dut ports, models the s-box and compares every output
module sboxChecker import ctrlPkg::*; (
    input logic       clk,
    input logic       rstN,
    input logic       inValid,
    input sboxMode_e  inMode,
    input logic [7:0] inData,
    input logic       outValid,
    input logic [7:0] outData
);

    int errCount  = 0;
    int inCount   = 0;
    int outCount  = 0;
    int tripCount = 0;
    int cycle     = 0;  // sample index, counted at negedge

    logic [7:0] fwdTab [256];
    logic [7:0] invTab [256];

    // bytes in flight, oldest first
    sboxMode_e  pendMode  [$];
    logic [7:0] pendData  [$];
    int         pendStamp [$];

    logic [7:0] knownFwd  [logic [7:0]];  // published vectors
    logic [7:0] knownInv  [logic [7:0]];
    logic [7:0] fwdSource [logic [7:0]];  // forward output -> its input

    // GF(2^8) product mod x^8 + x^4 + x^3 + x + 1
    function automatic logic [7:0] mul8(input logic [7:0] a, input logic [7:0] b);
        logic [15:0] p;
        p = '0;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                p ^= 16'(a) << i;
            end
        end
        for (int k = 15; k >= 8; k--) begin
            if (p[k]) begin
                p ^= 16'h11B << (k - 8);
            end
        end
        return p[7:0];
    endfunction

    // brute force search, zero stays zero
    function automatic logic [7:0] inv8(input logic [7:0] a);
        logic [7:0] res;
        res = 8'h00;
        for (int b = 1; b < 256; b++) begin
            if (mul8(a, 8'(b)) == 8'h01) begin
                res = 8'(b);
            end
        end
        return res;
    endfunction

    function automatic logic [7:0] affine(input logic [7:0] s);
        logic [7:0] b;
        for (int i = 0; i < 8; i++) begin
            b[i] = s[i] ^ s[(i + 4) % 8] ^ s[(i + 5) % 8] ^ s[(i + 6) % 8] ^ s[(i + 7) % 8];
        end
        return b ^ 8'h63;
    endfunction

    initial begin
        for (int x = 0; x < 256; x++) begin
            fwdTab[x] = affine(inv8(8'(x)));
        end
        for (int x = 0; x < 256; x++) begin
            invTab[fwdTab[x]] = 8'(x);  // s-box is a bijection
        end
    end

    function automatic void noteKnown(input sboxMode_e m, input logic [7:0] d,
                                      input logic [7:0] e);
        if (m == MODE_INV) begin
            knownInv[d] = e;
        end else begin
            knownFwd[d] = e;
        end
    endfunction

    function automatic int pendingCount();
        return pendData.size();
    endfunction

    // end of run bookkeeping
    function automatic void finalCheck();
        if (pendData.size() != 0) begin
            errCount++;
            $display("%0d accepted bytes never came out of the DUT", pendData.size());
        end
        if (inCount != outCount) begin
            errCount++;
            $display("DUT took %0d bytes but gave %0d outputs", inCount, outCount);
        end
    endfunction

    always @(negedge clk) begin : sampleBlk
        sboxMode_e  m;
        logic [7:0] d;
        logic [7:0] expByte;
        int         age;
        if (!rstN) begin
            if (outValid !== 1'b0) begin
                errCount++;
                $display("[FAIL] %0t: outValid is not low during reset", $time);
            end
        end else begin
            cycle++;
            if ($isunknown(outValid)) begin
                errCount++;
                $display("[FAIL] %0t: outValid is unknown", $time);
            end else if (outValid) begin
                outCount++;
                if (pendData.size() == 0) begin
                    errCount++;
                    $display("[FAIL] %0t: output 0x%02h without an input", $time, outData);
                end else begin
                    m   = pendMode.pop_front();
                    d   = pendData.pop_front();
                    age = cycle - pendStamp.pop_front();
                    expByte = (m == MODE_INV) ? invTab[d] : fwdTab[d];
                    if (age != PIPE_DEPTH) begin
                        errCount++;
                        $display("[FAIL] %0t: latency %0d for input 0x%02h, expected %0d",
                                 $time, age, d, PIPE_DEPTH);
                    end
                    if (outData !== expByte) begin
                        errCount++;
                        $display("[FAIL] %0t: %s 0x%02h gave 0x%02h, expected 0x%02h",
                                 $time, m.name(), d, outData, expByte);
                    end
                    if (m == MODE_FWD && knownFwd.exists(d) && outData !== knownFwd[d]) begin
                        errCount++;
                        $display("[FAIL] %0t: known vector fwd 0x%02h gave 0x%02h",
                                 $time, d, outData);
                    end
                    if (m == MODE_INV && knownInv.exists(d) && outData !== knownInv[d]) begin
                        errCount++;
                        $display("[FAIL] %0t: known vector inv 0x%02h gave 0x%02h",
                                 $time, d, outData);
                    end
                    if (m == MODE_FWD) begin
                        fwdSource[outData] = d;
                    end else if (fwdSource.exists(d)) begin
                        tripCount++;  // inverse of an earlier forward output
                        if (outData !== fwdSource[d]) begin
                            errCount++;
                            $display("[FAIL] %0t: round trip of 0x%02h came back as 0x%02h",
                                     $time, fwdSource[d], outData);
                        end
                    end
                end
            end else if (pendStamp.size() > 0 && cycle - pendStamp[0] >= PIPE_DEPTH) begin
                errCount++;
                $display("[FAIL] %0t: no output for input 0x%02h", $time, pendData[0]);
                void'(pendMode.pop_front());
                void'(pendData.pop_front());
                void'(pendStamp.pop_front());
            end
            if (inValid) begin
                inCount++;
                pendMode.push_back(inMode);
                pendData.push_back(inData);
                pendStamp.push_back(cycle);
            end
        end
    end

endmodule

//--- sim/sboxTb.sv
`timescale 1ns/1ps

module sboxTb import ctrlPkg::*;;

    localparam int          CLK_PERIOD   = 40;
    localparam int          DRIVE_DELAY  = 2;
    localparam int          RESET_CYCLES = 4;
    localparam int          RAND_COUNT   = 64;
    localparam int          DRAIN_LIMIT  = 20;
    localparam int unsigned SEED         = 32'hd47d10cf;

    typedef struct {
        sboxMode_e  mode;
        logic [7:0] data;
        logic [7:0] expected;
        int         idle;      // idle cycles after this byte
    } vecEntry_t;

    // published AES vectors
    vecEntry_t knownTab [5] = '{
        '{MODE_FWD, 8'h00, 8'h63, 0},
        '{MODE_FWD, 8'h01, 8'h7C, 2},
        '{MODE_FWD, 8'h53, 8'hED, 1},
        '{MODE_INV, 8'h63, 8'h00, 3},
        '{MODE_INV, 8'hED, 8'h53, 0}
    };

    logic       clk      = 1'b0;
    logic       rstN     = 1'b0;
    logic       inValid  = 1'b0;
    sboxMode_e  inMode   = MODE_FWD;
    logic [7:0] inData   = 8'h00;
    logic       outValid;
    logic [7:0] outData;

    int         timeoutCount = 0;
    logic       capture      = 1'b0;
    logic [7:0] fwdOuts [$];      // forward results fed back later

    always #(CLK_PERIOD / 2) clk = ~clk;

    sboxUnit u_sboxUnit (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .inMode   (inMode),
        .inData   (inData),
        .outValid (outValid),
        .outData  (outData)
    );

    sboxChecker uChecker (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .inMode   (inMode),
        .inData   (inData),
        .outValid (outValid),
        .outData  (outData)
    );

    always @(negedge clk) begin
        if (capture && outValid) begin
            fwdOuts.push_back(outData);
        end
    end

    // called just after an edge, returns just after the next one
    task automatic sendByte(input sboxMode_e m, input logic [7:0] d);
        inValid = 1'b1;
        inMode  = m;
        inData  = d;
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic idleCycles(input int n);
        inValid = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    // let the pipeline empty, bounded
    task automatic waitDrain(input string what);
        int waited;
        inValid = 1'b0;
        waited  = 0;
        while (uChecker.pendingCount() > 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (uChecker.pendingCount() > 0) begin
            timeoutCount++;
            $display("timeout while waiting for the %s bytes to leave the pipeline", what);
        end
        idleCycles(2);
    endtask

    initial begin
        void'($urandom(SEED));
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rstN = 1'b1;
        idleCycles(PIPE_DEPTH + 2);  // no output may appear here

        foreach (knownTab[i]) begin
            uChecker.noteKnown(knownTab[i].mode, knownTab[i].data, knownTab[i].expected);
            sendByte(knownTab[i].mode, knownTab[i].data);
            idleCycles(knownTab[i].idle);
        end
        waitDrain("known vector");

        for (int v = 0; v < 256; v++) begin
            sendByte(MODE_FWD, 8'(v));
        end
        waitDrain("forward sweep");

        for (int v = 0; v < 256; v++) begin
            sendByte(MODE_INV, 8'(v));
        end
        waitDrain("inverse sweep");

        // mode flips at random every cycle
        for (int n = 0; n < RAND_COUNT; n++) begin
            sendByte(sboxMode_e'(1'($urandom())), 8'($urandom()));
        end
        waitDrain("mixed mode");

        capture = 1'b1;
        for (int n = 0; n < RAND_COUNT; n++) begin
            sendByte(MODE_FWD, 8'($urandom()));
        end
        waitDrain("round trip forward");
        capture = 1'b0;
        foreach (fwdOuts[i]) begin
            sendByte(MODE_INV, fwdOuts[i]);
        end
        waitDrain("round trip inverse");

        uChecker.finalCheck();
        $display("errors %0d, timeouts %0d, inputs %0d, outputs %0d, round trips %0d",
                 uChecker.errCount, timeoutCount, uChecker.inCount, uChecker.outCount,
                 uChecker.tripCount);
        if (uChecker.errCount == 0 && timeoutCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- project.f
hw/ctrlPkg.sv
hw/sboxPkg.sv
hw/sboxStageIf.sv
hw/linMap.sv
hw/gfInverter.sv
hw/sboxFront.sv
hw/sboxBack.sv
hw/sboxUnit.sv
sim/sboxChecker.sv
sim/sboxTb.sv

//--- run.sh
#!/bin/sh
# build the testbench with verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f project.f --top-module sboxTb -o sboxSim \
    > build.log 2>&1 \
    && ./obj_dir/sboxSim > sim.log 2>&1 \
    || { echo "build or simulation failed"; cat build.log sim.log 2>/dev/null; exit 1; }

grep -q "^TEST OK$" sim.log \
    && { tail -n 2 sim.log; exit 0; } \
    || { cat sim.log; exit 1; }
